/* include/loader_defs.svh */
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Word and byte geometry
//////////////////////////////////////////////////////////////////////

// Address and data words on the write bus
`define LOADER_DATA_W 32

// One serial byte
`define LOADER_BYTE_W 8

`define LOADER_BYTES_PER_WORD 4

// Address word first, then data word
`define LOADER_BYTES_PER_FRAME 8

// Default serial bit period in clock cycles
`define LOADER_CLKS_PER_BIT 83

`endif

/* src/loader_pkg.sv */
`include "loader_defs.svh"

package loader_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus word with a byte lane view
  //////////////////////////////////////////////////////////////////////

  // Lane 0 is the least significant byte, the first one on the line
  typedef union packed {
    logic [`LOADER_DATA_W-1:0] word;
    logic [`LOADER_BYTES_PER_WORD-1:0][`LOADER_BYTE_W-1:0] bytes;
  } word_u;

  //////////////////////////////////////////////////////////////////////
  // Loader control states
  //////////////////////////////////////////////////////////////////////

  // WAIT_AW and WAIT_W name the transfer that is still outstanding
  typedef enum logic [2:0] {
    IDLE,
    COLLECT,
    ISSUE,
    WAIT_AW,
    WAIT_W,
    WAIT_B
  } loader_state_t;

endpackage

/* src/baud_timer.sv */
`timescale 1ns/10ps

module baud_timer #(
  parameter int CLKS_PER_BIT = 83
) (
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  input  logic i_stop,
  output logic o_tick
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  // First sample lands in the middle of the start bit
  localparam int HALF_CNT = (CLKS_PER_BIT - 1) / 2;
  localparam int FULL_CNT = CLKS_PER_BIT - 1;

  logic             running;
  logic [CNT_W-1:0] count;

  assign o_tick = running && (count == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      count   <= '0;
    end else if (i_start) begin
      running <= 1'b1;
      count   <= CNT_W'(HALF_CNT);
    end else if (i_stop) begin
      running <= 1'b0;
      count   <= '0;
    end else if (running) begin
      // Reload on each tick so later samples sit a full bit apart
      if (count == '0) begin
        count <= CNT_W'(FULL_CNT);
      end else begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/10ps
`include "loader_defs.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `LOADER_CLKS_PER_BIT
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_serial,
  output logic                      o_rx_valid,
  output logic [`LOADER_BYTE_W-1:0] o_rx_byte
);

  localparam int BIT_IDX_W = $clog2(`LOADER_BYTE_W);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic                      rx_meta;
  logic                      rx_sync;
  logic [1:0]                rx_state;
  logic [BIT_IDX_W-1:0]      bit_idx;
  logic [`LOADER_BYTE_W-1:0] shift_reg;
  logic                      tick;
  logic                      timer_start;
  logic                      timer_stop;

  // Two flops bring the idle-high line into the clock domain
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_serial;
      rx_sync <= rx_meta;
    end
  end

  assign timer_start = (rx_state == RX_IDLE) && !rx_sync;
  // Stop timing on a false start or after the stop-bit sample
  assign timer_stop  = tick && (((rx_state == RX_START) && rx_sync) || (rx_state == RX_STOP));

  baud_timer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_baud_timer (
    .clk    (clk),
    .rst    (rst),
    .i_start(timer_start),
    .i_stop (timer_stop),
    .o_tick (tick)
  );

  //////////////////////////////////////////////////////////////////////
  // Receive frame states
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_state   <= RX_IDLE;
      bit_idx    <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          bit_idx <= '0;
          if (!rx_sync) begin
            rx_state <= RX_START;
          end
        end
        RX_START: begin
          // Line back high at mid-bit means a glitch, not a start bit
          if (tick) begin
            rx_state <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == BIT_IDX_W'(`LOADER_BYTE_W - 1)) begin
              rx_state <= RX_STOP;
            end
          end
        end
        default: begin
          if (tick) begin
            o_rx_valid <= 1'b1;
            rx_state   <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if ((rx_state == RX_DATA) && tick) begin
      shift_reg <= {rx_sync, shift_reg[`LOADER_BYTE_W-1:1]};
    end
    if ((rx_state == RX_STOP) && tick) begin
      o_rx_byte <= shift_reg;
    end
  end

endmodule

/* src/word_assembler.sv */
`timescale 1ns/10ps
`include "loader_defs.svh"

module word_assembler (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_byte_strobe,
  input  logic [`LOADER_BYTE_W-1:0] i_byte,
  input  logic                      i_abort,
  output logic                      o_frame_done,
  output loader_pkg::word_u         o_addr,
  output loader_pkg::word_u         o_data
);

  localparam int IDX_W  = $clog2(`LOADER_BYTES_PER_FRAME);
  localparam int LANE_W = $clog2(`LOADER_BYTES_PER_WORD);

  logic [IDX_W-1:0]  byte_idx;
  logic              last_byte;
  loader_pkg::word_u work_addr;
  loader_pkg::word_u work_data;
  loader_pkg::word_u full_data;

  assign last_byte = (byte_idx == IDX_W'(`LOADER_BYTES_PER_FRAME - 1));

  // Data word as it stands once the final byte is in
  always_comb begin
    full_data = work_data;
    full_data.bytes[`LOADER_BYTES_PER_WORD-1] = i_byte;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_idx     <= '0;
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= i_byte_strobe && last_byte;
      if (i_abort) begin
        byte_idx <= '0;
      end else if (i_byte_strobe) begin
        byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
      end
    end
  end

  // Top index bit picks the word, low bits pick the lane
  always_ff @(posedge clk) begin
    if (i_byte_strobe) begin
      if (!byte_idx[IDX_W-1]) begin
        work_addr.bytes[byte_idx[LANE_W-1:0]] <= i_byte;
      end else begin
        work_data.bytes[byte_idx[LANE_W-1:0]] <= i_byte;
      end
      // Outputs only change when a whole frame is in
      if (last_byte) begin
        o_addr <= work_addr;
        o_data <= full_data;
      end
    end
  end

endmodule

/* src/loader_fsm.sv */
`timescale 1ns/10ps
`include "loader_defs.svh"

module loader_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_reprogram,
  input  logic                      i_rx_valid,
  input  logic                      i_frame_done,
  input  logic [`LOADER_DATA_W-1:0] i_addr,
  input  logic [`LOADER_DATA_W-1:0] i_data,
  input  logic                      i_awready,
  input  logic                      i_wready,
  input  logic                      i_bvalid,
  output logic                      o_byte_strobe,
  output logic                      o_abort,
  output logic                      o_busy,
  output logic                      o_awvalid,
  output logic [`LOADER_DATA_W-1:0] o_awaddr,
  output logic                      o_wvalid,
  output logic [`LOADER_DATA_W-1:0] o_wdata,
  output logic                      o_bready
);

  loader_pkg::loader_state_t state;
  logic                      capture_en;

  //////////////////////////////////////////////////////////////////////
  // Byte capture gating
  //////////////////////////////////////////////////////////////////////

  // Bytes are only taken while no write is in flight
  assign capture_en    = i_reprogram &&
                         ((state == loader_pkg::IDLE) || (state == loader_pkg::COLLECT));
  assign o_byte_strobe = i_rx_valid && capture_en;
  // A completed frame wins over a falling reprogram in the same cycle
  assign o_abort       = (state == loader_pkg::COLLECT) && !i_reprogram && !i_frame_done;
  assign o_busy        = (state != loader_pkg::IDLE);

  //////////////////////////////////////////////////////////////////////
  // Write bus sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= loader_pkg::IDLE;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
      o_bready  <= 1'b0;
    end else begin
      case (state)
        loader_pkg::IDLE: begin
          if (o_byte_strobe) begin
            state <= loader_pkg::COLLECT;
          end
        end
        loader_pkg::COLLECT: begin
          if (i_frame_done) begin
            state     <= loader_pkg::ISSUE;
            o_awvalid <= 1'b1;
            o_wvalid  <= 1'b1;
          end else if (!i_reprogram) begin
            state <= loader_pkg::IDLE;
          end
        end
        loader_pkg::ISSUE: begin
          // Both transfers outstanding and either may complete first
          if (i_awready) begin
            o_awvalid <= 1'b0;
          end
          if (i_wready) begin
            o_wvalid <= 1'b0;
          end
          if (i_awready && i_wready) begin
            state    <= loader_pkg::WAIT_B;
            o_bready <= 1'b1;
          end else if (i_awready) begin
            state <= loader_pkg::WAIT_W;
          end else if (i_wready) begin
            state <= loader_pkg::WAIT_AW;
          end
        end
        loader_pkg::WAIT_AW: begin
          if (i_awready) begin
            state     <= loader_pkg::WAIT_B;
            o_awvalid <= 1'b0;
            o_bready  <= 1'b1;
          end
        end
        loader_pkg::WAIT_W: begin
          if (i_wready) begin
            state    <= loader_pkg::WAIT_B;
            o_wvalid <= 1'b0;
            o_bready <= 1'b1;
          end
        end
        loader_pkg::WAIT_B: begin
          if (i_bvalid) begin
            state    <= loader_pkg::IDLE;
            o_bready <= 1'b0;
          end
        end
        default: begin
          state <= loader_pkg::IDLE;
        end
      endcase
    end
  end

  // Payload captured as the frame is handed to the bus
  always_ff @(posedge clk) begin
    if ((state == loader_pkg::COLLECT) && i_frame_done) begin
      o_awaddr <= i_addr;
      o_wdata  <= i_data;
    end
  end

endmodule

/* src/program_loader.sv */
`timescale 1ns/10ps
`include "loader_defs.svh"

module program_loader #(
  parameter int CLKS_PER_BIT = `LOADER_CLKS_PER_BIT
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_urx,
  input  logic                      i_reprogram,
  input  logic                      i_awready,
  input  logic                      i_wready,
  input  logic                      i_bvalid,
  output logic                      o_busy,
  output logic                      o_awvalid,
  output logic [`LOADER_DATA_W-1:0] o_awaddr,
  output logic                      o_wvalid,
  output logic [`LOADER_DATA_W-1:0] o_wdata,
  output logic                      o_bready
);

  logic                      rx_valid;
  logic [`LOADER_BYTE_W-1:0] rx_byte;
  logic                      byte_strobe;
  logic                      abort;
  logic                      frame_done;
  loader_pkg::word_u         asm_addr;
  loader_pkg::word_u         asm_data;

  //////////////////////////////////////////////////////////////////////
  // Serial receive and frame assembly
  //////////////////////////////////////////////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk       (clk),
    .rst       (rst),
    .i_serial  (i_urx),
    .o_rx_valid(rx_valid),
    .o_rx_byte (rx_byte)
  );

  word_assembler u_word_assembler (
    .clk          (clk),
    .rst          (rst),
    .i_byte_strobe(byte_strobe),
    .i_byte       (rx_byte),
    .i_abort      (abort),
    .o_frame_done (frame_done),
    .o_addr       (asm_addr),
    .o_data       (asm_data)
  );

  // Control and write bus
  loader_fsm u_loader_fsm (
    .clk          (clk),
    .rst          (rst),
    .i_reprogram  (i_reprogram),
    .i_rx_valid   (rx_valid),
    .i_frame_done (frame_done),
    .i_addr       (asm_addr.word),
    .i_data       (asm_data.word),
    .i_awready    (i_awready),
    .i_wready     (i_wready),
    .i_bvalid     (i_bvalid),
    .o_byte_strobe(byte_strobe),
    .o_abort      (abort),
    .o_busy       (o_busy),
    .o_awvalid    (o_awvalid),
    .o_awaddr     (o_awaddr),
    .o_wvalid     (o_wvalid),
    .o_wdata      (o_wdata),
    .o_bready     (o_bready)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
  parameter real PERIOD_NS = 10.0
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

endmodule

/* tests/tb_program_loader.sv */
`timescale 1ns/10ps
`include "loader_defs.svh"

module tb_program_loader;

  localparam int BIT_CLKS      = 8;
  localparam int RESET_CYCLES  = 16;
  localparam int GLITCH_CYCLES = 2;
  // Longer than one whole serial byte so a wrongly accepted byte shows up
  localparam int QUIET_CYCLES  = 12 * BIT_CLKS;
  localparam int VALID_TIMEOUT = 8 * BIT_CLKS;
  localparam int NUM_VECTORS   = 7;

  typedef struct packed {
    logic              reprogram;
    loader_pkg::word_u addr;
    loader_pkg::word_u data;
    logic [3:0]        nbytes;
    logic [7:0]        aw_delay;
    logic [7:0]        w_delay;
    logic              expect_write;
  } vector_t;

  logic              clk;
  logic              rst;
  logic              urx;
  logic              reprogram;
  logic              awready;
  logic              wready;
  logic              bvalid;
  logic              busy;
  logic              awvalid;
  loader_pkg::word_u awaddr;
  logic              wvalid;
  loader_pkg::word_u wdata;
  logic              bready;
  int                aw_count;
  int                w_count;
  int                expected_writes;
  vector_t           vectors [NUM_VECTORS];

  tb_clock u_clock (.o_clk(clk));

  program_loader #(
    .CLKS_PER_BIT(BIT_CLKS)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .i_urx      (urx),
    .i_reprogram(reprogram),
    .i_awready  (awready),
    .i_wready   (wready),
    .i_bvalid   (bvalid),
    .o_busy     (busy),
    .o_awvalid  (awvalid),
    .o_awaddr   (awaddr),
    .o_wvalid   (wvalid),
    .o_wdata    (wdata),
    .o_bready   (bready)
  );

  // Counts completed address and data transfers on the bus
  always @(posedge clk) begin
    if (rst) begin
      aw_count <= 0;
      w_count  <= 0;
    end else begin
      if (awvalid && awready) begin
        aw_count <= aw_count + 1;
      end
      if (wvalid && wready) begin
        w_count <= w_count + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare and failure tasks
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
      report_failure();
    end
  endtask

  task automatic check_word(input string name, input loader_pkg::word_u actual,
                            input loader_pkg::word_u expected);
    if (actual.word !== expected.word) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, actual.word,
               expected.word);
      report_failure();
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      report_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Serial line driver
  //////////////////////////////////////////////////////////////////////

  // Picks byte idx of the frame with the address word first and each word LSB first
  function automatic logic [`LOADER_BYTE_W-1:0] frame_byte(input vector_t v, input int idx);
    logic [`LOADER_DATA_W-1:0] src;
    src = (idx < `LOADER_BYTES_PER_WORD) ? v.addr.word : v.data.word;
    src = src >> (`LOADER_BYTE_W * (idx % `LOADER_BYTES_PER_WORD));
    return src[`LOADER_BYTE_W-1:0];
  endfunction

  task automatic drive_bit(input logic level);
    urx <= level;
    repeat (BIT_CLKS) @(posedge clk);
  endtask

  // Start bit, eight data bits LSB first, stop bit, one idle cycle
  task automatic send_byte(input logic [`LOADER_BYTE_W-1:0] value);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < `LOADER_BYTE_W; i++) begin
      drive_bit(value[i]);
    end
    drive_bit(1'b1);
    @(posedge clk);
  endtask

  task automatic send_glitch();
    reprogram <= 1'b1;
    urx       <= 1'b0;
    repeat (GLITCH_CYCLES) @(posedge clk);
    urx <= 1'b1;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Write bus responder
  //////////////////////////////////////////////////////////////////////

  task automatic wait_for_valids();
    int cycles;
    cycles = 0;
    while (!awvalid) begin
      if (cycles >= VALID_TIMEOUT) begin
        $display("Timeout: o_awvalid did not rise within %0d cycles of the last byte",
                 VALID_TIMEOUT);
        report_failure();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
    check_bit("o_wvalid", wvalid, 1'b1);
    check_bit("o_busy", busy, 1'b1);
  endtask

  task automatic serve_addr(input loader_pkg::word_u exp_addr, input int delay);
    int cycles;
    for (cycles = 0; cycles < delay; cycles++) begin
      @(posedge clk);
      check_bit("o_awvalid", awvalid, 1'b1);
      check_word("o_awaddr", awaddr, exp_addr);
      check_bit("o_bready", bready, 1'b0);
    end
    awready <= 1'b1;
    @(posedge clk);
    check_bit("o_awvalid", awvalid, 1'b1);
    check_word("o_awaddr", awaddr, exp_addr);
    check_bit("o_bready", bready, 1'b0);
    awready <= 1'b0;
    @(posedge clk);
    check_bit("o_awvalid", awvalid, 1'b0);
  endtask

  task automatic serve_data(input loader_pkg::word_u exp_data, input int delay);
    int cycles;
    for (cycles = 0; cycles < delay; cycles++) begin
      @(posedge clk);
      check_bit("o_wvalid", wvalid, 1'b1);
      check_word("o_wdata", wdata, exp_data);
      check_bit("o_bready", bready, 1'b0);
    end
    wready <= 1'b1;
    @(posedge clk);
    check_bit("o_wvalid", wvalid, 1'b1);
    check_word("o_wdata", wdata, exp_data);
    check_bit("o_bready", bready, 1'b0);
    wready <= 1'b0;
    @(posedge clk);
    check_bit("o_wvalid", wvalid, 1'b0);
  endtask

  // bready is up once both transfers are done and the response follows one cycle later
  task automatic serve_response();
    check_bit("o_bready", bready, 1'b1);
    @(posedge clk);
    check_bit("o_bready", bready, 1'b1);
    bvalid <= 1'b1;
    @(posedge clk);
    check_bit("o_bready", bready, 1'b1);
    check_bit("o_busy", busy, 1'b1);
    bvalid <= 1'b0;
    @(posedge clk);
    check_bit("o_bready", bready, 1'b0);
    check_bit("o_busy", busy, 1'b0);
  endtask

  task automatic expect_quiet(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(posedge clk);
      check_bit("o_busy", busy, 1'b0);
      check_bit("o_awvalid", awvalid, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and sequence
  //////////////////////////////////////////////////////////////////////

  task automatic fill_vectors();
    // reprogram, address, data, bytes, aw delay, w delay, write expected
    vectors[0] = '{1'b1, 32'h0000_1000, 32'hdead_beef, 4'd8, 8'd0, 8'd0, 1'b1};
    vectors[1] = '{1'b1, 32'h0000_1004, 32'h1234_5678, 4'd8, 8'd3, 8'd7, 1'b1};
    vectors[2] = '{1'b1, 32'h0000_1008, 32'ha5a5_5a5a, 4'd8, 8'd6, 8'd1, 1'b1};
    // Cut after five bytes
    vectors[3] = '{1'b1, 32'h2000_0000, 32'hffff_0000, 4'd5, 8'd0, 8'd0, 1'b0};
    vectors[4] = '{1'b1, 32'h0000_100c, 32'h0bad_f00d, 4'd8, 8'd2, 8'd2, 1'b1};
    // Line active while reprogram is low
    vectors[5] = '{1'b0, 32'h0000_2000, 32'h55aa_55aa, 4'd8, 8'd0, 8'd0, 1'b0};
    vectors[6] = '{1'b1, 32'h8000_0010, 32'h0102_0304, 4'd8, 8'd4, 8'd0, 1'b1};
  endtask

  task automatic apply_vector(input vector_t v);
    int i;
    check_bit("o_busy", busy, 1'b0);
    reprogram <= v.reprogram;
    @(posedge clk);
    for (i = 0; i < v.nbytes; i++) begin
      send_byte(frame_byte(v, i));
      check_bit("o_busy", busy, v.reprogram);
    end
    if (v.expect_write) begin
      wait_for_valids();
      fork
        serve_addr(v.addr, v.aw_delay);
        serve_data(v.data, v.w_delay);
      join
      serve_response();
    end else begin
      // Drop reprogram to discard a partial frame
      if (v.reprogram) begin
        reprogram <= 1'b0;
        repeat (2) @(posedge clk);
      end
      expect_quiet(QUIET_CYCLES);
    end
  endtask

  initial begin
    int n;
    urx             = 1'b1;
    rst             = 1'b1;
    reprogram       = 1'b0;
    awready         = 1'b0;
    wready          = 1'b0;
    bvalid          = 1'b0;
    expected_writes = 0;
    fill_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("o_busy", busy, 1'b0);
    check_bit("o_awvalid", awvalid, 1'b0);
    check_bit("o_wvalid", wvalid, 1'b0);
    check_bit("o_bready", bready, 1'b0);

    // Short low pulse must not start a byte
    send_glitch();
    expect_quiet(QUIET_CYCLES);

    for (n = 0; n < NUM_VECTORS; n++) begin
      apply_vector(vectors[n]);
      if (vectors[n].expect_write) begin
        expected_writes++;
      end
      check_count("address transfers", aw_count, expected_writes);
      check_count("data transfers", w_count, expected_writes);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
src/loader_pkg.sv
src/baud_timer.sv
src/uart_rx.sv
src/word_assembler.sv
src/loader_fsm.sv
src/program_loader.sv
tests/tb_clock.sv
tests/tb_program_loader.sv
